//--- include/isa_defines.svh
`ifndef ISA_DEFINES_SVH
`define ISA_DEFINES_SVH

// major opcodes
`define SPECIAL_OP      6'b000000
`define SPECIAL2_OP     6'b011100
`define SPECIAL3_OP     6'b011111

// immediate opcodes, also used directly as operation classes
`define ADDI_OP         6'b001000
`define ADDIU_OP        6'b001001
`define SLTI_OP         6'b001010
`define SLTIU_OP        6'b001011
`define ANDI_OP         6'b001100
`define ORI_OP          6'b001101
`define XORI_OP         6'b001110
`define LUI_OP          6'b001111

// special funct field
`define SLL             6'b000000
`define SRL             6'b000010
`define SRA             6'b000011
`define SLLV            6'b000100
`define SRLV            6'b000110
`define SRAV            6'b000111
`define ADD             6'b100000
`define ADDU            6'b100001
`define SUB             6'b100010
`define SUBU            6'b100011
`define AND             6'b100100
`define OR              6'b100101
`define XOR             6'b100110
`define NOR             6'b100111
`define SLT             6'b101010
`define SLTU            6'b101011

// special2 and special3 funct, bshfl selector in the sa field
`define CLZ             6'b100000
`define CLO             6'b100001
`define BSHFL           6'b100000
`define WSBH_SA         5'b00010
`define SEB_SA          5'b10000
`define SEH_SA          5'b11000

// operation classes that do not match an opcode
`define R_TYPE_OP       6'b000000
`define CLZ_OP          6'b110000
`define CLO_OP          6'b110001
`define SEB_OP          6'b110010
`define SEH_OP          6'b110011
`define WSBH_OP         6'b110100
`define ROTR_OP         6'b110101
`define ROTRV_OP        6'b110110
`define INVALID_OP      6'b111111

// alu control codes
`define NONE_CONTROL    8'd0
`define AND_CONTROL     8'd1
`define OR_CONTROL      8'd2
`define XOR_CONTROL     8'd3
`define NOR_CONTROL     8'd4
`define ADD_CONTROL     8'd5
`define ADDU_CONTROL    8'd6
`define SUB_CONTROL     8'd7
`define SUBU_CONTROL    8'd8
`define SLT_CONTROL     8'd9
`define SLTU_CONTROL    8'd10
`define SLL_CONTROL     8'd11
`define SRL_CONTROL     8'd12
`define SRA_CONTROL     8'd13
`define SLLV_CONTROL    8'd14
`define SRLV_CONTROL    8'd15
`define SRAV_CONTROL    8'd16
`define ROTR_CONTROL    8'd17
`define ROTRV_CONTROL   8'd18
`define LUI_CONTROL     8'd19
`define CLZ_CONTROL     8'd20
`define CLO_CONTROL     8'd21
`define SEB_CONTROL     8'd22
`define SEH_CONTROL     8'd23
`define WSBH_CONTROL    8'd24

`endif

//--- hdl/mips_pkg.sv
`include "isa_defines.svh"

package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [5:0] op_class_t;

	typedef enum logic [7:0] {
		ALU_NONE  = `NONE_CONTROL,
		ALU_AND   = `AND_CONTROL,
		ALU_OR    = `OR_CONTROL,
		ALU_XOR   = `XOR_CONTROL,
		ALU_NOR   = `NOR_CONTROL,
		ALU_ADD   = `ADD_CONTROL,
		ALU_ADDU  = `ADDU_CONTROL,
		ALU_SUB   = `SUB_CONTROL,
		ALU_SUBU  = `SUBU_CONTROL,
		ALU_SLT   = `SLT_CONTROL,
		ALU_SLTU  = `SLTU_CONTROL,
		ALU_SLL   = `SLL_CONTROL,
		ALU_SRL   = `SRL_CONTROL,
		ALU_SRA   = `SRA_CONTROL,
		ALU_SLLV  = `SLLV_CONTROL,
		ALU_SRLV  = `SRLV_CONTROL,
		ALU_SRAV  = `SRAV_CONTROL,
		ALU_ROTR  = `ROTR_CONTROL,
		ALU_ROTRV = `ROTRV_CONTROL,
		ALU_LUI   = `LUI_CONTROL,
		ALU_CLZ   = `CLZ_CONTROL,
		ALU_CLO   = `CLO_CONTROL,
		ALU_SEB   = `SEB_CONTROL,
		ALU_SEH   = `SEH_CONTROL,
		ALU_WSBH  = `WSBH_CONTROL
	} alu_ctrl_t;

	typedef struct packed {
		word_t instr;
		word_t rs_val;
		word_t rt_val;
	} instr_req_t;

	typedef struct packed {
		alu_ctrl_t ctrl;
		word_t a;
		word_t b;
		reg_idx_t shamt;
		reg_idx_t dest;
		logic we;
		logic illegal;
	} dec_op_t;

	typedef struct packed {
		word_t value;
		reg_idx_t dest;
		logic we;
		logic illegal;
	} exec_result_t;

endpackage

//--- hdl/aludec.sv
`include "isa_defines.svh"
`timescale 1ns/1ps

module aludec (
	input mips_pkg::op_class_t op_class,
	input logic [5:0] funct,
	output mips_pkg::alu_ctrl_t alu_ctrl
);
	import mips_pkg::*;

	always_comb begin
		case (op_class)
			`R_TYPE_OP: begin
				case (funct)
					// arithmetic and logic
					`AND:    alu_ctrl = ALU_AND;
					`OR:     alu_ctrl = ALU_OR;
					`XOR:    alu_ctrl = ALU_XOR;
					`NOR:    alu_ctrl = ALU_NOR;
					`ADD:    alu_ctrl = ALU_ADD;
					`ADDU:   alu_ctrl = ALU_ADDU;
					`SUB:    alu_ctrl = ALU_SUB;
					`SUBU:   alu_ctrl = ALU_SUBU;
					`SLT:    alu_ctrl = ALU_SLT;
					`SLTU:   alu_ctrl = ALU_SLTU;

					// shifts
					`SLL:    alu_ctrl = ALU_SLL;
					`SRL:    alu_ctrl = ALU_SRL;
					`SRA:    alu_ctrl = ALU_SRA;
					`SLLV:   alu_ctrl = ALU_SLLV;
					`SRLV:   alu_ctrl = ALU_SRLV;
					`SRAV:   alu_ctrl = ALU_SRAV;

					// mult, div, hilo, movn/movz and traps land here
					default: alu_ctrl = ALU_NONE;
				endcase
			end

			// immediate forms
			`ADDI_OP:  alu_ctrl = ALU_ADD;
			`ADDIU_OP: alu_ctrl = ALU_ADDU;
			`SLTI_OP:  alu_ctrl = ALU_SLT;
			`SLTIU_OP: alu_ctrl = ALU_SLTU;
			`ANDI_OP:  alu_ctrl = ALU_AND;
			`ORI_OP:   alu_ctrl = ALU_OR;
			`XORI_OP:  alu_ctrl = ALU_XOR;
			`LUI_OP:   alu_ctrl = ALU_LUI;

			// special2 / special3 classes
			`CLZ_OP:   alu_ctrl = ALU_CLZ;
			`CLO_OP:   alu_ctrl = ALU_CLO;
			`SEB_OP:   alu_ctrl = ALU_SEB;
			`SEH_OP:   alu_ctrl = ALU_SEH;
			`WSBH_OP:  alu_ctrl = ALU_WSBH;
			`ROTR_OP:  alu_ctrl = ALU_ROTR;
			`ROTRV_OP: alu_ctrl = ALU_ROTRV;

			default:   alu_ctrl = ALU_NONE;
		endcase
	end

endmodule

//--- hdl/instr_decode.sv
`include "isa_defines.svh"
`timescale 1ns/1ps

module instr_decode (
	input logic clk,
	input logic rst,
	input logic in_valid,
	output logic in_ready,
	input mips_pkg::instr_req_t in_req,
	output logic dec_valid,
	input logic dec_ready,
	output mips_pkg::dec_op_t dec_op
);
	import mips_pkg::*;

	word_t instr;
	logic [5:0] opcode;
	logic [5:0] funct;
	reg_idx_t rt;
	reg_idx_t rd;
	reg_idx_t shamt;
	op_class_t op_class;
	alu_ctrl_t alu_ctrl;
	logic is_imm;
	word_t imm_ext;
	dec_op_t next_op;

	assign instr = in_req.instr;
	assign opcode = instr[31:26];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign shamt = instr[10:6];
	assign funct = instr[5:0];

	// operation class, special encodings split out here
	always_comb begin
		op_class = `INVALID_OP;
		is_imm = 1'b0;
		case (opcode)
			`SPECIAL_OP: begin
				// rotr reuses srl with rs[0] set, rotrv reuses srlv with sa[0] set
				if (funct == `SRL && instr[21])
					op_class = `ROTR_OP;
				else if (funct == `SRLV && instr[6])
					op_class = `ROTRV_OP;
				else
					op_class = `R_TYPE_OP;
			end
			`SPECIAL2_OP: begin
				if (funct == `CLZ)
					op_class = `CLZ_OP;
				else if (funct == `CLO)
					op_class = `CLO_OP;
			end
			`SPECIAL3_OP: begin
				if (funct == `BSHFL) begin
					case (shamt)
						`SEB_SA:  op_class = `SEB_OP;
						`SEH_SA:  op_class = `SEH_OP;
						`WSBH_SA: op_class = `WSBH_OP;
						default:  op_class = `INVALID_OP;
					endcase
				end
			end
			`ADDI_OP, `ADDIU_OP, `SLTI_OP, `SLTIU_OP,
			`ANDI_OP, `ORI_OP, `XORI_OP, `LUI_OP: begin
				op_class = opcode;
				is_imm = 1'b1;
			end
			default: op_class = `INVALID_OP;
		endcase
	end

	// immediate extension
	always_comb begin
		case (opcode)
			`ANDI_OP, `ORI_OP, `XORI_OP: imm_ext = {16'h0000, instr[15:0]};
			`LUI_OP:                     imm_ext = {instr[15:0], 16'h0000};
			default:                     imm_ext = {{16{instr[15]}}, instr[15:0]};
		endcase
	end

	aludec aludec_inst (
		.op_class(op_class),
		.funct(funct),
		.alu_ctrl(alu_ctrl)
	);

	always_comb begin
		next_op.ctrl = alu_ctrl;
		next_op.a = in_req.rs_val;
		next_op.b = is_imm ? imm_ext : in_req.rt_val;
		next_op.shamt = shamt;
		next_op.dest = is_imm ? rt : rd;
		next_op.illegal = (alu_ctrl == ALU_NONE);
		next_op.we = (alu_ctrl != ALU_NONE);
	end

	assign in_ready = !dec_valid || dec_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			dec_valid <= 1'b0;
		end else if (in_valid && in_ready) begin
			dec_valid <= 1'b1;
		end else if (dec_ready) begin
			dec_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			dec_op <= next_op;
	end

	// held item must not change until the queue takes it
	assert property (@(posedge clk) disable iff (rst)
		(dec_valid && !dec_ready) |=> (dec_valid && $stable(dec_op)));

endmodule

//--- hdl/issue_queue.sv
`timescale 1ns/1ps

module issue_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input logic clk,
	input logic rst,
	input logic dec_valid,
	output logic dec_ready,
	input mips_pkg::dec_op_t dec_op,
	output logic q_valid,
	input logic q_ready,
	output mips_pkg::dec_op_t q_op
);
	import mips_pkg::*;

	localparam int PTR_W = $clog2(QUEUE_DEPTH);

	dec_op_t mem [QUEUE_DEPTH];
	// one extra bit tells full from empty
	logic [PTR_W:0] wr_ptr;
	logic [PTR_W:0] rd_ptr;
	logic [PTR_W:0] used;
	logic full;
	logic push;
	logic pop;

	assign used = wr_ptr - rd_ptr;
	assign full = (used == (PTR_W + 1)'(QUEUE_DEPTH));
	assign q_valid = (used != '0);
	assign q_op = mem[rd_ptr[PTR_W-1:0]];

	assign pop = q_valid && q_ready;
	assign dec_ready = !full || pop;
	assign push = dec_valid && dec_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr[PTR_W-1:0]] <= dec_op;
	end

	// occupancy never wraps in either direction
	assert property (@(posedge clk) disable iff (rst)
		used <= (PTR_W + 1)'(QUEUE_DEPTH));

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
	input logic clk,
	input logic rst,
	input logic q_valid,
	output logic q_ready,
	input mips_pkg::dec_op_t q_op,
	output logic out_valid,
	input logic out_ready,
	output mips_pkg::exec_result_t out_res
);
	import mips_pkg::*;

	word_t a;
	word_t b;
	reg_idx_t var_sa;
	word_t value;
	logic pop;

	function automatic word_t rotate_right(word_t v, reg_idx_t n);
		logic [63:0] d;
		d = {v, v} >> n;
		return d[31:0];
	endfunction

	// 32 when v is zero
	function automatic word_t lead_zeros(word_t v);
		word_t n;
		logic found;
		n = '0;
		found = 1'b0;
		for (int i = 31; i >= 0; i--) begin
			if (v[i])
				found = 1'b1;
			else if (!found)
				n = n + 1'b1;
		end
		return n;
	endfunction

	assign a = q_op.a;
	assign b = q_op.b;
	assign var_sa = q_op.a[4:0];

	always_comb begin
		case (q_op.ctrl)
			// no overflow trap, so signed and unsigned forms match
			ALU_ADD, ALU_ADDU: value = a + b;
			ALU_SUB, ALU_SUBU: value = a - b;
			ALU_AND:   value = a & b;
			ALU_OR:    value = a | b;
			ALU_XOR:   value = a ^ b;
			ALU_NOR:   value = ~(a | b);
			ALU_SLT:   value = {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU:  value = {31'b0, a < b};
			ALU_SLL:   value = b << q_op.shamt;
			ALU_SRL:   value = b >> q_op.shamt;
			ALU_SRA:   value = $signed(b) >>> q_op.shamt;
			ALU_SLLV:  value = b << var_sa;
			ALU_SRLV:  value = b >> var_sa;
			ALU_SRAV:  value = $signed(b) >>> var_sa;
			ALU_ROTR:  value = rotate_right(b, q_op.shamt);
			ALU_ROTRV: value = rotate_right(b, var_sa);
			// immediate already sits in the upper half
			ALU_LUI:   value = b;
			ALU_CLZ:   value = lead_zeros(a);
			ALU_CLO:   value = lead_zeros(~a);
			ALU_SEB:   value = {{24{b[7]}}, b[7:0]};
			ALU_SEH:   value = {{16{b[15]}}, b[15:0]};
			ALU_WSBH:  value = {b[23:16], b[31:24], b[7:0], b[15:8]};
			default:   value = '0;
		endcase
	end

	assign q_ready = !out_valid || out_ready;
	assign pop = q_valid && q_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (pop) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			out_res.value <= q_op.illegal ? '0 : value;
			out_res.dest <= q_op.dest;
			out_res.we <= q_op.we && !q_op.illegal;
			out_res.illegal <= q_op.illegal;
		end
	end

	// result holds while the sink stalls
	assert property (@(posedge clk) disable iff (rst)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_res)));

endmodule

//--- hdl/alu_exec_unit.sv
`timescale 1ns/1ps

module alu_exec_unit #(
	parameter int QUEUE_DEPTH = 4
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	output logic in_ready,
	input mips_pkg::instr_req_t in_req,
	output logic out_valid,
	input logic out_ready,
	output mips_pkg::exec_result_t out_res
);
	import mips_pkg::*;

	logic dec_valid;
	logic dec_ready;
	dec_op_t dec_op;
	logic q_valid;
	logic q_ready;
	dec_op_t q_op;

	instr_decode instr_decode_inst (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_req(in_req),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.dec_op(dec_op)
	);

	issue_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) issue_queue_inst (
		.clk(clk),
		.rst(rst),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.dec_op(dec_op),
		.q_valid(q_valid),
		.q_ready(q_ready),
		.q_op(q_op)
	);

	alu alu_inst (
		.clk(clk),
		.rst(rst),
		.q_valid(q_valid),
		.q_ready(q_ready),
		.q_op(q_op),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_res(out_res)
	);

endmodule

//--- test/alu_checker.sv
`timescale 1ns/1ps

module alu_checker #(
	parameter int STALL_TEST = 6
) (
	input logic clk,
	input logic rst,
	input logic out_valid,
	input logic out_ready,
	input mips_pkg::exec_result_t out_res,
	input logic in_stalled,
	output int seen,
	output logic done,
	output int fail_tests
);
	import mips_pkg::*;

	localparam int COLS = 7;

	logic [31:0] stim [0:511];
	int vec_count;
	int pass_tests;
	logic test_bad;

	// word 0 is the vector count, rows of COLS words follow
	function automatic logic [31:0] field_at(int line, int col);
		return stim[1 + line * COLS + col];
	endfunction

	task automatic compare_result(int line);
		word_t exp_value;
		reg_idx_t exp_dest;
		logic exp_illegal;
		logic exp_we;
		exp_value = field_at(line, 4);
		exp_dest = reg_idx_t'(field_at(line, 5));
		exp_illegal = (field_at(line, 6) != 0);
		// an illegal op never writes back
		exp_we = !exp_illegal;
		if (out_res.value !== exp_value) begin
			$display("ERR %0t: line %0d value %h, expected %h",
				$time, line, out_res.value, exp_value);
			test_bad = 1'b1;
		end
		if (out_res.dest !== exp_dest) begin
			$display("ERR %0t: line %0d dest %0d, expected %0d",
				$time, line, out_res.dest, exp_dest);
			test_bad = 1'b1;
		end
		if (out_res.we !== exp_we || out_res.illegal !== exp_illegal) begin
			$display("ERR %0t: line %0d we/illegal %b/%b, expected %b/%b",
				$time, line, out_res.we, out_res.illegal, exp_we, exp_illegal);
			test_bad = 1'b1;
		end
	endtask

	task automatic close_test(int tnum);
		if (tnum == STALL_TEST && !in_stalled) begin
			$display("test %0d: in_ready never dropped during the stall run", tnum);
			test_bad = 1'b1;
		end
		if (test_bad) begin
			$display("test %0d: FAIL", tnum);
			fail_tests++;
		end else begin
			$display("test %0d: ok", tnum);
			pass_tests++;
		end
		test_bad = 1'b0;
	endtask

	initial begin
		$readmemh("test/alu_stimulus.txt", stim);
		vec_count = int'(stim[0]);
		seen = 0;
		done = 1'b0;
		pass_tests = 0;
		fail_tests = 0;
		test_bad = 1'b0;
	end

	// mid cycle, so the handshake seen here is the one taken on the next rising edge
	always @(negedge clk) begin
		if (!rst && out_valid && out_ready) begin
			if (seen >= vec_count) begin
				$display("an extra result came out after the last expected one");
				fail_tests++;
			end else begin
				compare_result(seen);
				if (seen == vec_count - 1 || field_at(seen + 1, 0) != field_at(seen, 0))
					close_test(int'(field_at(seen, 0)));
				seen++;
				if (seen == vec_count) begin
					done = 1'b1;
					$display("summary: %0d passed, %0d failed", pass_tests, fail_tests);
				end
			end
		end
	end

endmodule

//--- test/tb_alu_exec_unit.sv
`timescale 1ns/1ps

module tb_alu_exec_unit;
	import mips_pkg::*;

	localparam int QUEUE_DEPTH = 4;
	localparam int COLS = 7;
	localparam int STALL_TEST = 6;
	// longer than everything the unit can hold
	localparam int STALL_RUN = 16;

	logic clk;
	logic rst;
	logic in_valid;
	logic in_ready;
	instr_req_t in_req;
	logic out_valid;
	logic out_ready;
	exec_result_t out_res;

	logic [31:0] stim [0:511];
	int vec_count;
	int seen;
	logic done;
	int fail_tests;
	logic in_stalled;
	logic [31:0] lfsr;
	int cycles;
	int limit;

	alu_exec_unit #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) alu_exec_unit_inst (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_req(in_req),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_res(out_res)
	);

	alu_checker #(
		.STALL_TEST(STALL_TEST)
	) checker_inst (
		.clk(clk),
		.rst(rst),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_res(out_res),
		.in_stalled(in_stalled),
		.seen(seen),
		.done(done),
		.fail_tests(fail_tests)
	);

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	function automatic logic [31:0] word_at(int line, int col);
		return stim[1 + line * COLS + col];
	endfunction

	function automatic int test_at(int line);
		if (line >= vec_count)
			return 0;
		return int'(word_at(line, 0));
	endfunction

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// input stream
	initial begin
		int idx;
		logic fire;
		rst = 1'b1;
		in_valid = 1'b0;
		in_req = '0;
		in_stalled = 1'b0;
		$readmemh("test/alu_stimulus.txt", stim);
		vec_count = int'(stim[0]);
		repeat (10) @(posedge clk);
		#0.5;
		rst = 1'b0;
		idx = 0;
		while (idx < vec_count) begin
			in_valid = 1'b1;
			in_req.instr = word_at(idx, 1);
			in_req.rs_val = word_at(idx, 2);
			in_req.rt_val = word_at(idx, 3);
			@(negedge clk);
			fire = in_ready;
			if (!in_ready && test_at(idx) == STALL_TEST)
				in_stalled = 1'b1;
			@(posedge clk);
			#0.5;
			if (fire)
				idx++;
		end
		in_valid = 1'b0;
	end

	// output back-pressure
	initial begin
		int stall_left;
		logic stall_done;
		logic b0;
		logic b1;
		out_ready = 1'b1;
		lfsr = 32'd78546;
		stall_left = 0;
		stall_done = 1'b0;
		forever begin
			@(posedge clk);
			#0.5;
			if (stall_left > 0) begin
				out_ready = 1'b0;
				stall_left--;
			end else if (test_at(seen) == STALL_TEST && !stall_done) begin
				out_ready = 1'b0;
				stall_done = 1'b1;
				stall_left = STALL_RUN - 1;
			end else if (test_at(seen) == STALL_TEST) begin
				b0 = lfsr[0];
				lfsr = lfsr_step(lfsr);
				b1 = lfsr[0];
				lfsr = lfsr_step(lfsr);
				out_ready = b0 | b1;
			end else begin
				out_ready = 1'b1;
			end
		end
	end

	initial begin
		cycles = 0;
		@(posedge clk);
		limit = vec_count * 8 + 200;
		while (!done && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (!done) begin
			$display("timeout: only %0d of %0d results came out after %0d cycles",
				seen, vec_count, cycles);
			$display("test failed");
		end else begin
			if (fail_tests != 0) begin
				$display("test failed");
			end else begin
				$display("test passed");
			end
		end
		$finish;
	end

endmodule

//--- test/alu_stimulus.txt
// first word: number of vectors
// then per vector (hex): test, instr, rs_val, rt_val, expected value, dest, illegal
2e
1 00221820 00000005 00000007 0000000c 03 0
1 00222022 00000003 00000005 fffffffe 04 0
1 00222824 f0f0ff00 0ff0f0f0 00f0f000 05 0
1 00223025 f0f0ff00 0ff0f0f0 fff0fff0 06 0
1 00224027 12345678 0000ffff edcb0000 08 0
1 0022482a ffffffff 00000001 00000001 09 0
1 0022502b ffffffff 00000001 00000000 0a 0
2 00021900 00000000 80000001 00000010 03 0
2 00022102 00000000 80000010 08000001 04 0
2 00022a03 00000000 80001200 ff800012 05 0
2 00223004 00000024 00000003 00000030 06 0
2 00223807 00000010 f0000000 fffff000 07 0
2 00224a02 00000000 12345678 78123456 09 0
2 00225046 00000004 12345678 81234567 0a 0
3 2023ffff 00000010 deadbeef 0000000f 03 0
3 28248000 ffff0000 deadbeef 00000001 04 0
3 2c25ffff fffffffe deadbeef 00000001 05 0
3 30268f0f ffffffff deadbeef 00008f0f 06 0
3 34278001 12340000 deadbeef 12348001 07 0
3 3828ffff 0000f0f0 deadbeef 00000f0f 08 0
3 3c09beef 00000000 deadbeef beef0000 09 0
3 242a8000 00010000 deadbeef 00008000 0a 0
4 70231820 00000000 00000000 00000020 03 0
4 70242020 00010000 00000000 0000000f 04 0
4 70252821 ffffffff 00000000 00000020 05 0
4 70263021 ff800000 00000000 00000009 06 0
4 70273821 00000000 00000000 00000000 07 0
4 7c021c20 00000000 12345680 ffffff80 03 0
4 7c022620 00000000 ffff7fff 00007fff 04 0
4 7c0228a0 00000000 11223344 22114433 05 0
5 00220018 00000003 00000004 00000000 00 1
5 00220034 00000003 00000003 00000000 00 1
5 8c200004 00001000 00000000 00000000 00 1
5 00223826 f0f0ff00 0ff0f0f0 ff000ff0 07 0
6 24010001 00000100 00000000 00000101 01 0
6 24020002 00000200 00000000 00000202 02 0
6 24030003 00000300 00000000 00000303 03 0
6 00222020 11111111 22222222 33333333 04 0
6 00022840 00000000 40000000 80000000 05 0
6 00220018 00000001 00000002 00000000 00 1
6 3c071234 00000000 00000000 12340000 07 0
6 70284020 00000001 00000000 0000001f 08 0
6 342900ff 0f000000 00000000 0f0000ff 09 0
6 00225022 00000000 00000001 ffffffff 0a 0
6 7c0258a0 00000000 aabbccdd bbaaddcc 0b 0
6 382c0f0f ffffffff 00000000 fffff0f0 0c 0

//--- all.f
+incdir+include
hdl/mips_pkg.sv
hdl/aludec.sv
hdl/instr_decode.sv
hdl/issue_queue.sv
hdl/alu.sv
hdl/alu_exec_unit.sv
test/alu_checker.sv
test/tb_alu_exec_unit.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -sv -f all.f --top-module tb_alu_exec_unit -o tb_alu_exec_unit

run: compile
	./obj_dir/tb_alu_exec_unit > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
